// ==== pe_array.f ====
+incdir+src
src/pe_array_pkg.sv
src/array_control.sv
src/bias_regs.sv
src/mac_array.sv
src/row_reducer.sv
src/output_packer.sv
src/pe_array_top.sv
testbench/pe_array_checker.sv
testbench/tb_pe_array.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_pe_array -f pe_array.f -o sim_pe_array
./obj_dir/sim_pe_array > sim.log 2>&1
cat sim.log
if grep -q "Some tests failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// ==== testbench/tb_pe_array.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module tb_pe_array
	import pe_array_pkg::*;
;

	localparam int RESET_LEN = 16;
	localparam int T1_LEN = 30;
	localparam int T2_LEN = 20;
	localparam int T3_LEN = 27;
	localparam int T4_LEN = 22;
	localparam int T5_LEN = 12;
	localparam int END_LEN = 2;
	localparam int CYCLE_LIMIT = RESET_LEN + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN
		+ END_LEN + 50;

	logic clk;
	logic reset;
	logic enable;
	logic clear;
	logic bias_we;
	logic [1:0] bias_addr;
	logic buffer_load;
	logic done_layer;
	prec_t out_prec;
	shift_t shift;
	data_vec_t in_vec;
	weight_mat_t weights;
	data_vec_t out_vec;
	int error_count;
	int check_count;
	int cycles;
	int seed_value;
	acc_vec_t target;
	data_vec_t lane_bytes;
	int value;

	pe_array_top u_pe_array_top (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.clear(clear),
		.bias_we(bias_we),
		.bias_addr(bias_addr),
		.buffer_load(buffer_load),
		.done_layer(done_layer),
		.out_prec(out_prec),
		.shift(shift),
		.in_vec(in_vec),
		.weights(weights),
		.out_vec(out_vec)
	);

	pe_array_checker u_checker (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.clear(clear),
		.bias_we(bias_we),
		.bias_addr(bias_addr),
		.buffer_load(buffer_load),
		.done_layer(done_layer),
		.out_prec(out_prec),
		.shift(shift),
		.in_vec(in_vec),
		.weights(weights),
		.out_vec(out_vec),
		.error_count(error_count),
		.check_count(check_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("Timeout: the run went past %0d clock cycles without finishing.", CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	// inputs change a little after the rising edge, so the DUT samples settled values.
	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	function automatic data_t small_val();
		return data_t'(int'($urandom_range(4, 0)) - 2);
	endfunction

	task automatic fill_operands(input bit full_range);
		for (int j = 0; j < `N_DIM; j++) begin
			in_vec[j] = full_range ? data_t'($urandom) : small_val();
			for (int i = 0; i < `N_DIM; i++) begin
				weights[i][j] = full_range ? data_t'($urandom) : small_val();
			end
		end
	endtask

	// one clear cycle, then len cycles that keep adding fresh products.
	task automatic accumulate_run(input int len, input bit full_range);
		fill_operands(full_range);
		clear = 1'b1;
		next_cycle();
		clear = 1'b0;
		for (int n = 0; n < len; n++) begin
			fill_operands(full_range);
			next_cycle();
		end
	endtask

	task automatic write_bias_lane(input logic [1:0] lane, input data_vec_t bytes);
		weights = '0;
		in_vec = bytes;
		bias_addr = lane;
		bias_we = 1'b1;
		next_cycle();
		bias_we = 1'b0;
	endtask

	initial begin
		seed_value = $urandom(32'h88ec_a811);
		reset = 1'b0;
		enable = 1'b0;
		clear = 1'b0;
		bias_we = 1'b0;
		bias_addr = 2'd0;
		buffer_load = 1'b0;
		done_layer = 1'b0;
		out_prec = `PREC_8;
		shift = '0;
		in_vec = '0;
		weights = '0;
		repeat (RESET_LEN) @(posedge clk);
		#5;
		reset = 1'b1;

		// out_vec must stay zero while nothing is enabled.
		next_cycle();
		next_cycle();
		enable = 1'b1;
		for (int run = 0; run < 4; run++) begin
			accumulate_run(int'($urandom_range(6, 1)), 1'b0);
		end

		// biases of moderate size so the shift brings them back into range.
		for (int round = 0; round < 2; round++) begin
			for (int r = 0; r < `N_DIM; r++) begin
				value = int'($urandom_range(65535, 0)) - 32768;
				if (r == 0) begin
					value = -int'($urandom_range(32767, 0)) - 1;
				end
				target[r] = acc_t'(value);
			end
			for (int lane = 0; lane < 4; lane++) begin
				for (int r = 0; r < `N_DIM; r++) begin
					lane_bytes[r] = target[r][`DATA_W*lane +: `DATA_W];
				end
				write_bias_lane(2'(lane), lane_bytes);
			end
			shift = shift_t'($urandom_range(10, 6));
			accumulate_run(4, 1'b0);
		end

		for (int run = 0; run < 3; run++) begin
			shift = shift_t'($urandom_range(20, 0));
			accumulate_run(8, 1'b1);
		end

		out_prec = `PREC_4;
		shift = '0;

		// with the biases back at zero the row results stay small enough to pack.
		for (int lane = 0; lane < 4; lane++) begin
			write_bias_lane(2'(lane), '0);
		end
		for (int round = 0; round < 2; round++) begin
			accumulate_run(3, 1'b0);
			buffer_load = 1'b1;
			next_cycle();
			buffer_load = 1'b0;
			accumulate_run(3, 1'b0);
		end

		fill_operands(1'b0);
		buffer_load = 1'b1;
		next_cycle();
		done_layer = 1'b1;
		next_cycle();
		buffer_load = 1'b0;
		done_layer = 1'b0;
		next_cycle();
		enable = 1'b0;
		clear = 1'b1;
		bias_we = 1'b1;
		buffer_load = 1'b1;
		for (int n = 0; n < 6; n++) begin
			bias_addr = 2'($urandom_range(3, 0));
			out_prec = prec_t'(n % 2);
			fill_operands(1'b1);
			next_cycle();
		end
		enable = 1'b1;
		clear = 1'b0;
		bias_we = 1'b0;
		buffer_load = 1'b0;
		out_prec = `PREC_8;
		next_cycle();
		next_cycle();

		next_cycle();
		next_cycle();
		$display("Closing report: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== testbench/pe_array_checker.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module pe_array_checker
	import pe_array_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic enable,
	input logic clear,
	input logic bias_we,
	input logic [1:0] bias_addr,
	input logic buffer_load,
	input logic done_layer,
	input prec_t out_prec,
	input shift_t shift,
	input data_vec_t in_vec,
	input weight_mat_t weights,
	input data_vec_t out_vec,
	output int error_count,
	output int check_count
);

	acc_mat_t acc_m;
	acc_vec_t bias_m;
	data_vec_t held_m;
	data_vec_t want_vec;
	int errors = 0;
	int checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	function automatic acc_t pe_product(input data_t a, input data_t w);
		int prod;

		prod = int'(a) * int'(w);
		return acc_t'(prod);
	endfunction

	function automatic data_t clamp_int8(input acc_t value);
		if (value > 127) begin
			return data_t'(127);
		end
		if (value < -128) begin
			return data_t'(-128);
		end
		return data_t'(value);
	endfunction

	// row i is the wrapped sum of its four accumulators plus its bias, then scaled.
	function automatic data_vec_t row_results(input acc_mat_t a, input acc_vec_t b,
			input shift_t sh);
		data_vec_t res;
		acc_t total;

		for (int i = 0; i < `N_DIM; i++) begin
			total = b[i];
			for (int j = 0; j < `N_DIM; j++) begin
				total = total + a[i][j];
			end
			res[i] = clamp_int8(total >>> sh);
		end
		return res;
	endfunction

	// the reference function for out_vec.
	function automatic data_vec_t expected_out(input acc_mat_t a, input acc_vec_t b,
			input data_vec_t held, input shift_t sh, input prec_t prec);
		data_vec_t cur;
		data_vec_t word;

		cur = row_results(a, b, sh);
		if (prec == `PREC_8) begin
			return cur;
		end
		word[0] = {held[1][3:0], held[0][3:0]};
		word[1] = {held[3][3:0], held[2][3:0]};
		word[2] = {cur[1][3:0], cur[0][3:0]};
		word[3] = {cur[3][3:0], cur[2][3:0]};
		return word;
	endfunction

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			acc_m <= '0;
			bias_m <= '0;
			held_m <= '0;
		end else if (enable) begin
			for (int i = 0; i < `N_DIM; i++) begin
				for (int j = 0; j < `N_DIM; j++) begin
					if (clear) begin
						acc_m[i][j] <= pe_product(in_vec[j], weights[i][j]);
					end else begin
						acc_m[i][j] <= acc_m[i][j] + pe_product(in_vec[j], weights[i][j]);
					end
				end
			end
			if (bias_we) begin
				for (int r = 0; r < `N_DIM; r++) begin
					bias_m[r][`DATA_W*bias_addr +: `DATA_W] <= in_vec[r];
				end
			end
			if (done_layer) begin
				held_m <= '0;
			end else if (buffer_load) begin
				held_m <= row_results(acc_m, bias_m, shift);
			end
		end
	end

	always @(negedge clk) begin
		if (reset) begin
			want_vec = expected_out(acc_m, bias_m, held_m, shift, out_prec);
			checks = checks + 1;
			if (out_vec !== want_vec) begin
				errors = errors + 1;
				$display("[ERROR] %0d ns: out_vec mismatch, expected %h actual %h",
					$time, want_vec, out_vec);
			end
		end
	end

endmodule

// ==== src/pe_array_top.sv ====
`timescale 1ns/1ps

module pe_array_top
	import pe_array_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic enable,
	input logic clear,
	input logic bias_we,
	input logic [1:0] bias_addr,
	input logic buffer_load,
	input logic done_layer,
	input prec_t out_prec,
	input shift_t shift,
	input data_vec_t in_vec,
	input weight_mat_t weights,
	output data_vec_t out_vec
);

	ctrl_t ctrl;
	acc_mat_t acc;
	acc_vec_t bias;
	data_vec_t result;

	array_control u_array_control (
		.enable(enable),
		.clear(clear),
		.bias_we(bias_we),
		.buffer_load(buffer_load),
		.done_layer(done_layer),
		.bias_addr(bias_addr),
		.ctrl(ctrl)
	);

	// bias bytes share the activation input.
	bias_regs u_bias_regs (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.bias_bytes(in_vec),
		.bias(bias)
	);

	mac_array u_mac_array (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.in_vec(in_vec),
		.weights(weights),
		.acc(acc)
	);

	row_reducer u_row_reducer (
		.acc(acc),
		.bias(bias),
		.shift(shift),
		.result(result)
	);

	output_packer u_output_packer (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.out_prec(out_prec),
		.result(result),
		.out_vec(out_vec)
	);

endmodule

// ==== src/output_packer.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module output_packer
	import pe_array_pkg::*;
(
	input logic clk,
	input logic reset,
	input ctrl_t ctrl,
	input prec_t out_prec,
	input data_vec_t result,
	output data_vec_t out_vec
);

	localparam int NIBBLE_W = `DATA_W / 2;
	localparam int HALF = `N_DIM / 2;

	data_vec_t buffer_q;
	data_vec_t packed_word;

	// holds an earlier result vector for the 4-bit packing.
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			buffer_q <= '0;
		end else if (ctrl.buf_clear) begin
			buffer_q <= '0;
		end else if (ctrl.buf_load) begin
			buffer_q <= result;
		end
	end

	// the low lanes carry the buffered vector and the high lanes the current one.
	// each lane holds two neighbouring elements, the odd one in the upper nibble.
	always_comb begin
		packed_word = '0;
		for (int k = 0; k < HALF; k++) begin
			packed_word[k] = {buffer_q[2*k+1][NIBBLE_W-1:0],
				buffer_q[2*k][NIBBLE_W-1:0]};
			packed_word[k+HALF] = {result[2*k+1][NIBBLE_W-1:0],
				result[2*k][NIBBLE_W-1:0]};
		end
	end

	always_comb begin
		if (out_prec == `PREC_4) begin
			out_vec = packed_word;
		end else begin
			out_vec = result;
		end
	end

endmodule

// ==== src/row_reducer.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module row_reducer
	import pe_array_pkg::*;
(
	input acc_mat_t acc,
	input acc_vec_t bias,
	input shift_t shift,
	output data_vec_t result
);

	localparam acc_t SAT_MAX = acc_t'((2 ** (`DATA_W - 1)) - 1);
	localparam acc_t SAT_MIN = -acc_t'(2 ** (`DATA_W - 1));

	// clamps a signed accumulator value into the int8 range.
	function automatic data_t saturate(input acc_t value);
		data_t clamped;

		if (value > SAT_MAX) begin
			clamped = data_t'(SAT_MAX);
		end else if (value < SAT_MIN) begin
			clamped = data_t'(SAT_MIN);
		end else begin
			clamped = data_t'(value);
		end
		return clamped;
	endfunction

	for (genvar r = 0; r < `N_DIM; r++) begin : g_row
		acc_t pair_lo;
		acc_t pair_hi;
		acc_t row_sum;
		acc_t biased;
		acc_t scaled;

		// first level of the tree adds neighbouring columns.
		assign pair_lo = acc[r][0] + acc[r][1];
		assign pair_hi = acc[r][2] + acc[r][3];

		// second level closes the tree.
		assign row_sum = pair_lo + pair_hi;

		assign biased = row_sum + bias[r];

		// the shift keeps the sign so negative sums round toward minus infinity.
		assign scaled = biased >>> shift;

		assign result[r] = saturate(scaled);
	end

endmodule

// ==== src/mac_array.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module mac_array
	import pe_array_pkg::*;
(
	input logic clk,
	input logic reset,
	input ctrl_t ctrl,
	input data_vec_t in_vec,
	input weight_mat_t weights,
	output acc_mat_t acc
);

	for (genvar i = 0; i < `N_DIM; i++) begin : g_row
		for (genvar j = 0; j < `N_DIM; j++) begin : g_col
			acc_t product;
			acc_t acc_q;

			// column j always sees activation j.
			// each row therefore builds the dot product for output i.
			assign product = acc_t'(in_vec[j]) * acc_t'(weights[i][j]);

			// the sum wraps at the accumulator width.
			always_ff @(posedge clk or negedge reset) begin
				if (!reset) begin
					acc_q <= '0;
				end else if (ctrl.mac_start) begin
					acc_q <= product;
				end else if (ctrl.mac_en) begin
					acc_q <= acc_q + product;
				end
			end

			assign acc[i][j] = acc_q;
		end
	end

endmodule

// ==== src/bias_regs.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module bias_regs
	import pe_array_pkg::*;
(
	input logic clk,
	input logic reset,
	input ctrl_t ctrl,
	input data_vec_t bias_bytes,
	output acc_vec_t bias
);

	// row r takes its byte from element r of the input vector.
	// all rows write the same lane in the same cycle.
	for (genvar r = 0; r < `N_DIM; r++) begin : g_row
		for (genvar b = 0; b < BIAS_LANES; b++) begin : g_lane
			always_ff @(posedge clk or negedge reset) begin
				if (!reset) begin
					bias[r][b*`DATA_W +: `DATA_W] <= '0;
				end else if (ctrl.bias_byte_we[b]) begin
					bias[r][b*`DATA_W +: `DATA_W] <= bias_bytes[r];
				end
			end
		end
	end

endmodule

// ==== src/array_control.sv ====
`timescale 1ns/1ps

module array_control
	import pe_array_pkg::*;
(
	input logic enable,
	input logic clear,
	input logic bias_we,
	input logic buffer_load,
	input logic done_layer,
	input logic [1:0] bias_addr,
	output ctrl_t ctrl
);

	logic [BIAS_LANES-1:0] lane_sel;
	logic bias_write;
	logic layer_end;

	// bias_addr picks the byte lane that every row bias takes this cycle.
	assign lane_sel = BIAS_LANES'(1) << bias_addr;

	assign bias_write = enable && bias_we;
	assign layer_end = enable && done_layer;

	always_comb begin
		ctrl = '0;

		// the array accumulates on every enabled cycle.
		// clear makes the accumulation start from the current product.
		ctrl.mac_en = enable;
		ctrl.mac_start = enable && clear;

		if (bias_write) begin
			ctrl.bias_byte_we = lane_sel;
		end

		// the end of a layer empties the buffer, so it wins over a load.
		ctrl.buf_clear = layer_end;
		ctrl.buf_load = enable && buffer_load && !done_layer;
	end

endmodule

// ==== src/pe_array_pkg.sv ====
`include "pe_array_cfg.svh"

package pe_array_pkg;

	// a row bias is written one activation-wide byte lane at a time.
	localparam int BIAS_LANES = `ACC_W / `DATA_W;

	typedef logic signed [`DATA_W-1:0] data_t;
	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic [`SHIFT_W-1:0] shift_t;
	typedef logic prec_t;

	// element k of a vector sits in the k-th byte from the bottom.
	typedef data_t [`N_DIM-1:0] data_vec_t;

	// indexed as weights[row][column].
	typedef data_vec_t [`N_DIM-1:0] weight_mat_t;

	typedef acc_t [`N_DIM-1:0] acc_vec_t;

	// indexed as acc[row][column], like the weights.
	typedef acc_vec_t [`N_DIM-1:0] acc_mat_t;

	// per-cycle datapath commands.
	typedef struct packed {
		logic mac_en;
		logic mac_start;
		logic [BIAS_LANES-1:0] bias_byte_we;
		logic buf_load;
		logic buf_clear;
	} ctrl_t;

endpackage

// ==== src/pe_array_cfg.svh ====
`ifndef PE_ARRAY_CFG_SVH
`define PE_ARRAY_CFG_SVH

// array side, rows and columns are the same size.
`define N_DIM 4

// activation and weight width, also the width of a row result.
`define DATA_W 8

// accumulator and row bias width.
`define ACC_W 32

// fixed-point shift applied after the bias add.
`define SHIFT_W 5

// output precision codes.
`define PREC_8 1'b0
`define PREC_4 1'b1

`endif
